//--- axi_wr_beat_counter.sv
`default_nettype none

module axi_wr_beat_counter (
	input wire logic AClk,
	input wire logic ARst,
	input wire logic load,
	input wire logic [axi_wr_pkg::BLEN_W-1:0] load_len,
	input wire logic step,
	output logic last
);

	// beats still to send in this burst
	logic [axi_wr_pkg::CNT_W-1:0] remaining;

	//////////////////////////////
	// count
	//////////////////////////////
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			remaining <= '0;
		end else if (load) begin
			// len is beats minus one
			remaining <= axi_wr_pkg::CNT_W'(load_len) + 1'b1;
		end else if (step && (remaining != '0)) begin
			remaining <= remaining - 1'b1;
		end
	end

	// final beat of the burst
	assign last = (remaining == axi_wr_pkg::CNT_W'(1));

endmodule

`default_nettype wire

//--- axi_wr_checker.sv
`default_nettype none

module axi_wr_checker (
	input wire logic AClk,
	input wire logic ARst,
	input wire axi_wr_pkg::wr_cmd_t aw,
	input wire logic aw_valid,
	input wire logic aw_ready,
	input wire axi_wr_pkg::wr_beat_t w,
	input wire logic w_valid,
	input wire logic w_ready,
	input wire logic w_last,
	input wire logic rsp_valid
);

	// failures so far
	int fail_count = 0;

	// AW holds until accepted
	assert property (@(posedge AClk) disable iff (!ARst)
		aw_valid && !aw_ready |=> aw_valid && aw == $past(aw))
	else begin
		$error("aw_valid dropped or AW payload changed before aw_ready");
		fail_count++;
	end

	// W holds until accepted, w_last included
	assert property (@(posedge AClk) disable iff (!ARst)
		w_valid && !w_ready |=> w_valid && w == $past(w) && w_last == $past(w_last))
	else begin
		$error("w_valid dropped or W payload changed before w_ready");
		fail_count++;
	end

	assert property (@(posedge AClk) disable iff (!ARst) w_last |-> w_valid)
	else begin
		$error("w_last high without w_valid");
		fail_count++;
	end

	assert property (@(posedge AClk) disable iff (!ARst) rsp_valid |=> !rsp_valid)
	else begin
		$error("rsp_valid held longer than one cycle");
		fail_count++;
	end

endmodule

bind axi_wr_master axi_wr_checker u_checker (.*);

`default_nettype wire

//--- axi_wr_cmd_regs.sv
`default_nettype none

module axi_wr_cmd_regs (
	input wire logic AClk,
	input wire logic ARst,
	input wire logic cmd_load,
	input wire axi_wr_pkg::wr_cmd_t cmd,
	output axi_wr_pkg::wr_cmd_t aw,
	output logic [axi_wr_pkg::BLEN_W-1:0] burst_len,
	input wire logic rsp_load,
	input wire axi_wr_pkg::wr_rsp_t b,
	output axi_wr_pkg::wr_rsp_t rsp_out
);

	// command held for the whole transaction
	axi_wr_pkg::wr_cmd_t cmd_q;
	// last response taken from B
	axi_wr_pkg::wr_rsp_t rsp_q;

	//////////////////////////////
	// command capture
	//////////////////////////////
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			cmd_q <= '0;
		end else if (cmd_load) begin
			cmd_q <= cmd;
		end
	end

	// AW payload comes straight from the register,
	// so it stays put while aw_valid waits for aw_ready
	assign aw = cmd_q;

	// length for the beat counter
	assign burst_len = cmd_q.len;

	//////////////////////////////
	// response capture
	//////////////////////////////
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			rsp_q <= '0;
		end else if (rsp_load) begin
			rsp_q <= b;
		end
	end

	// valid alongside the rsp_valid pulse
	assign rsp_out = rsp_q;

endmodule

`default_nettype wire

//--- axi_wr_data_fifo.sv
`default_nettype none

module axi_wr_data_fifo (
	input wire logic AClk,
	input wire logic ARst,
	input wire logic push,
	input wire axi_wr_pkg::wr_beat_t push_beat,
	output logic full,
	input wire logic pop,
	output axi_wr_pkg::wr_beat_t head,
	output logic empty
);

	// beat storage
	axi_wr_pkg::wr_beat_t mem [axi_wr_pkg::FIFO_DEPTH];

	logic [axi_wr_pkg::FIFO_AW-1:0] wr_ptr;
	logic [axi_wr_pkg::FIFO_AW-1:0] rd_ptr;
	// one extra bit so a full FIFO is distinct from an empty one
	logic [axi_wr_pkg::FIFO_AW:0] count;

	logic do_push;
	logic do_pop;

	// requests against the wrong flag are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == axi_wr_pkg::FIFO_DEPTH);
	assign empty = (count == '0);

	//////////////////////////////
	// write side
	//////////////////////////////
	always_ff @(posedge AClk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_beat;
		end
	end

	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			wr_ptr <= '0;
		end else if (do_push) begin
			// depth is a power of two, pointer wraps by itself
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	//////////////////////////////
	// read side
	//////////////////////////////
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// show-ahead, oldest beat always on the output
	assign head = mem[rd_ptr];

	// occupancy
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- axi_wr_fsm.sv
`default_nettype none

module axi_wr_fsm (
	input wire logic AClk,
	input wire logic ARst,
	input wire logic cmd_valid,
	output logic cmd_ready,
	output logic cmd_load,
	output logic aw_valid,
	input wire logic aw_ready,
	output logic cnt_load,
	input wire logic fifo_empty,
	output logic w_valid,
	input wire logic w_ready,
	input wire logic beat_last,
	output logic w_last,
	output logic fifo_pop,
	input wire logic b_valid,
	output logic b_ready,
	output logic rsp_load,
	output logic rsp_valid
);

	axi_wr_pkg::wr_state_t state;
	axi_wr_pkg::wr_state_t state_nxt;

	//////////////////////////////
	// state register
	//////////////////////////////
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			state <= axi_wr_pkg::ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			axi_wr_pkg::ST_IDLE: begin
				if (cmd_valid) begin
					state_nxt = axi_wr_pkg::ST_ADDR;
				end
			end
			axi_wr_pkg::ST_ADDR: begin
				if (aw_ready) begin
					state_nxt = axi_wr_pkg::ST_DATA;
				end
			end
			axi_wr_pkg::ST_DATA: begin
				// leave on the handshake of the final beat
				if (fifo_pop && beat_last) begin
					state_nxt = axi_wr_pkg::ST_RESP;
				end
			end
			axi_wr_pkg::ST_RESP: begin
				if (b_valid) begin
					state_nxt = axi_wr_pkg::ST_IDLE;
				end
			end
			default: state_nxt = axi_wr_pkg::ST_IDLE;
		endcase
	end

	//////////////////////////////
	// handshake controls
	//////////////////////////////
	assign cmd_ready = (state == axi_wr_pkg::ST_IDLE);
	assign cmd_load = cmd_ready && cmd_valid;

	assign aw_valid = (state == axi_wr_pkg::ST_ADDR);
	// counter loads on the AW handshake
	assign cnt_load = aw_valid && aw_ready;

	// only offer W when a beat is buffered
	assign w_valid = (state == axi_wr_pkg::ST_DATA) && !fifo_empty;
	assign fifo_pop = w_valid && w_ready;
	assign w_last = w_valid && beat_last;

	assign b_ready = (state == axi_wr_pkg::ST_RESP);
	assign rsp_load = b_ready && b_valid;

	// one-cycle pulse, lines up with the captured response
	always_ff @(posedge AClk or negedge ARst) begin
		if (!ARst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= rsp_load;
		end
	end

endmodule

`default_nettype wire

//--- axi_wr_master.sv
`default_nettype none

module axi_wr_master (
	input wire logic AClk,
	input wire logic ARst,
	// upstream command
	input wire axi_wr_pkg::wr_cmd_t cmd,
	input wire logic cmd_valid,
	output logic cmd_ready,
	// upstream write beats
	input wire axi_wr_pkg::wr_beat_t beat_in,
	input wire logic beat_valid,
	output logic beat_ready,
	// upstream response
	output axi_wr_pkg::wr_rsp_t rsp_out,
	output logic rsp_valid,
	// AXI write address
	output axi_wr_pkg::wr_cmd_t aw,
	output logic aw_valid,
	input wire logic aw_ready,
	// AXI write data
	output axi_wr_pkg::wr_beat_t w,
	output logic w_last,
	output logic w_valid,
	input wire logic w_ready,
	// AXI write response
	input wire axi_wr_pkg::wr_rsp_t b,
	input wire logic b_valid,
	output logic b_ready
);

	logic cmd_load;
	logic cnt_load;
	logic rsp_load;
	logic fifo_pop;
	logic fifo_full;
	logic fifo_empty;
	logic beat_last;
	logic [axi_wr_pkg::BLEN_W-1:0] burst_len;

	//////////////////////////////
	// control
	//////////////////////////////
	axi_wr_fsm u_fsm (
		.AClk(AClk),
		.ARst(ARst),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd_load(cmd_load),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.cnt_load(cnt_load),
		.fifo_empty(fifo_empty),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.beat_last(beat_last),
		.w_last(w_last),
		.fifo_pop(fifo_pop),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.rsp_load(rsp_load),
		.rsp_valid(rsp_valid)
	);

	// each W handshake is one beat down
	axi_wr_beat_counter u_beat_counter (
		.AClk(AClk),
		.ARst(ARst),
		.load(cnt_load),
		.load_len(burst_len),
		.step(fifo_pop),
		.last(beat_last)
	);

	//////////////////////////////
	// data path
	//////////////////////////////
	axi_wr_data_fifo u_data_fifo (
		.AClk(AClk),
		.ARst(ARst),
		.push(beat_valid),
		.push_beat(beat_in),
		.full(fifo_full),
		.pop(fifo_pop),
		.head(w),
		.empty(fifo_empty)
	);

	assign beat_ready = !fifo_full;

	axi_wr_cmd_regs u_cmd_regs (
		.AClk(AClk),
		.ARst(ARst),
		.cmd_load(cmd_load),
		.cmd(cmd),
		.aw(aw),
		.burst_len(burst_len),
		.rsp_load(rsp_load),
		.b(b),
		.rsp_out(rsp_out)
	);

endmodule

`default_nettype wire

//--- axi_wr_monitor.sv
`default_nettype none

module axi_wr_monitor #(
	parameter int N_ROWS = 6
) (
	input wire logic AClk,
	input wire logic ARst,
	input wire logic cmd_ready,
	input wire logic beat_valid,
	input wire logic beat_ready,
	input wire axi_wr_pkg::wr_cmd_t aw,
	input wire logic aw_valid,
	input wire logic aw_ready,
	input wire axi_wr_pkg::wr_beat_t w,
	input wire logic w_last,
	input wire logic w_valid,
	input wire logic w_ready,
	input wire logic b_valid,
	input wire logic b_ready,
	input wire axi_wr_pkg::wr_rsp_t rsp_out,
	input wire logic rsp_valid,
	input wire logic [8*12-1:0] tbl_name [N_ROWS],
	input wire axi_wr_pkg::wr_cmd_t tbl_cmd [N_ROWS],
	input wire logic [axi_wr_pkg::DATA_W-1:0] tbl_base [N_ROWS],
	input wire logic [axi_wr_pkg::STRB_W-1:0] tbl_strb [N_ROWS],
	input wire logic [1:0] tbl_resp [N_ROWS],
	output int err_count,
	output int rsp_count
);

	int aw_idx = 0;
	int w_row = 0;
	int beat_k = 0;
	int b_count = 0;
	// beats pushed but not yet sent on W
	int pending = 0;
	int rst_edges = 0;
	bit saw_full = 1'b0;
	logic exp_last;
	// data word wraps at the bus width
	logic [axi_wr_pkg::DATA_W-1:0] exp_data;

	initial begin
		err_count = 0;
		rsp_count = 0;
	end

	task automatic expect_eq(input logic [8*12-1:0] tname, input string field,
			input logic [63:0] exp, input logic [63:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %0s %0s expected %0h actual %0h", tname, field, exp, act);
			err_count++;
		end
	endtask

	task automatic report_fault(input string msg);
		$display("ERROR: %0s", msg);
		err_count++;
	endtask

	always @(posedge AClk) begin
		if (!ARst) begin
			rst_edges++;
			// aw_valid, w_valid, w_last, b_ready, rsp_valid low, cmd_ready high
			if (rst_edges > 1) begin
				expect_eq("reset", "controls", 64'(6'b000001),
					64'({aw_valid, w_valid, w_last, b_ready, rsp_valid, cmd_ready}));
			end
		end else begin
			expect_eq("fifo_level", "beat_ready", 64'(pending < axi_wr_pkg::FIFO_DEPTH),
				64'(beat_ready));
			saw_full = saw_full || (pending == axi_wr_pkg::FIFO_DEPTH);
			pending = pending + int'(beat_valid && beat_ready) - int'(w_valid && w_ready);

			if (aw_valid && aw_ready) begin
				if (aw_idx >= N_ROWS) begin
					report_fault("AW handshake with no command left in the table");
				end else begin
					expect_eq(tbl_name[aw_idx], "awaddr", 64'(tbl_cmd[aw_idx].addr), 64'(aw.addr));
					expect_eq(tbl_name[aw_idx], "awid", 64'(tbl_cmd[aw_idx].id), 64'(aw.id));
					expect_eq(tbl_name[aw_idx], "awlen",
						64'(axi_wr_pkg::LEN_W'(tbl_cmd[aw_idx].len)),
						64'(axi_wr_pkg::LEN_W'(aw.len)));
					expect_eq(tbl_name[aw_idx], "awsize", 64'(tbl_cmd[aw_idx].size), 64'(aw.size));
					expect_eq(tbl_name[aw_idx], "awburst", 64'(tbl_cmd[aw_idx].burst),
						64'(aw.burst));
				end
				aw_idx++;
			end

			if (w_valid && w_ready) begin
				if (w_row >= N_ROWS || w_row >= aw_idx) begin
					report_fault("W beat sent with no matching AW handshake");
				end else begin
					exp_last = (beat_k == int'(tbl_cmd[w_row].len));
					exp_data = tbl_base[w_row] + axi_wr_pkg::DATA_W'(beat_k);
					expect_eq(tbl_name[w_row], "wdata", 64'(exp_data), 64'(w.data));
					expect_eq(tbl_name[w_row], "wstrb", 64'(tbl_strb[w_row]), 64'(w.strb));
					expect_eq(tbl_name[w_row], "wlast", 64'(exp_last), 64'(w_last));
					beat_k = exp_last ? 0 : beat_k + 1;
					w_row = exp_last ? w_row + 1 : w_row;
				end
			end

			// response before the B count moves, so an early pulse is caught
			if (rsp_valid) begin
				if (rsp_count >= N_ROWS) begin
					report_fault("response pulse beyond the number of commands");
				end else if (rsp_count >= b_count) begin
					report_fault("response pulse before its B handshake");
				end else begin
					expect_eq(tbl_name[rsp_count], "resp", 64'(tbl_resp[rsp_count]),
						64'(rsp_out.resp));
					expect_eq(tbl_name[rsp_count], "rsp_id", 64'(tbl_cmd[rsp_count].id),
						64'(rsp_out.id));
				end
				rsp_count++;
				if (rsp_count == N_ROWS && !saw_full) begin
					report_fault("data FIFO never reached full during the run");
				end
			end
			if (b_valid && b_ready) begin
				b_count++;
			end
		end
	end

endmodule

`default_nettype wire

//--- axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

	//////////////////////////////
	// bus widths
	//////////////////////////////
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int ID_W = 4;
	// AWLEN as it appears on the bus
	localparam int LEN_W = 8;

	//////////////////////////////
	// limits
	//////////////////////////////
	localparam int MAX_BEATS = 16;
	// upstream length field, beats minus one
	localparam int BLEN_W = $clog2(MAX_BEATS);
	// beats remaining, 0 to MAX_BEATS
	localparam int CNT_W = $clog2(MAX_BEATS + 1);
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// burst type codes
	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [1:0] BURST_WRAP = 2'b10;

	// response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_EXOKAY = 2'b01;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// write controller states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ADDR = 2'd1,
		ST_DATA = 2'd2,
		ST_RESP = 2'd3
	} wr_state_t;

	//////////////////////////////
	// payload structs
	//////////////////////////////
	// upstream command, also the AW payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0] id;
		logic [BLEN_W-1:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} wr_cmd_t;

	// one write beat
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} wr_beat_t;

	// B payload and upstream response
	typedef struct packed {
		logic [1:0] resp;
		logic [ID_W-1:0] id;
	} wr_rsp_t;

endpackage

`default_nettype wire

//--- list.f
axi_wr_pkg.sv
axi_wr_data_fifo.sv
axi_wr_beat_counter.sv
axi_wr_cmd_regs.sv
axi_wr_fsm.sv
axi_wr_master.sv
axi_wr_checker.sv
axi_wr_monitor.sv
tb_axi_wr_master.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_axi_wr_master -f list.f \
	&& ./obj_dir/Vtb_axi_wr_master +verilator+error+limit+1000 | tee /dev/stderr \
	| grep -x "PASS: all tests" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb_axi_wr_master.sv
`default_nettype none

module tb_axi_wr_master;

	localparam int N_ROWS = 6;
	localparam int CLK_PERIOD = 20;
	// watchdog budget in cycles per beat, plus a fixed margin
	localparam int BEAT_ALLOW = 12;
	localparam int MARGIN = 200;

	logic AClk = 1'b0;
	logic ARst;
	axi_wr_pkg::wr_cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	axi_wr_pkg::wr_beat_t beat_in;
	logic beat_valid;
	logic beat_ready;
	axi_wr_pkg::wr_rsp_t rsp_out;
	logic rsp_valid;
	axi_wr_pkg::wr_cmd_t aw;
	logic aw_valid;
	logic aw_ready = 1'b0;
	axi_wr_pkg::wr_beat_t w;
	logic w_last;
	logic w_valid;
	logic w_ready = 1'b0;
	axi_wr_pkg::wr_rsp_t b = '0;
	logic b_valid = 1'b0;
	logic b_ready;
	int err_count;
	int rsp_count;

	//////////////////////////////
	// stimulus table
	//////////////////////////////
	logic [8*12-1:0] tbl_name [N_ROWS];
	axi_wr_pkg::wr_cmd_t tbl_cmd [N_ROWS];
	logic [axi_wr_pkg::DATA_W-1:0] tbl_base [N_ROWS];
	logic [axi_wr_pkg::STRB_W-1:0] tbl_strb [N_ROWS];
	logic [1:0] tbl_resp [N_ROWS];

	// slave model state
	int seed = 32'hefd5;
	int aw_seen = 0;
	axi_wr_pkg::wr_rsp_t rsp_word;
	axi_wr_pkg::wr_rsp_t open_q [$];
	axi_wr_pkg::wr_rsp_t b_q [$];

	axi_wr_master u_dut (.*);
	axi_wr_monitor #(.N_ROWS(N_ROWS)) u_mon (.*);

	always #(CLK_PERIOD / 2) AClk = ~AClk;

	task automatic add_row(input int i, input logic [8*12-1:0] name,
			input logic [axi_wr_pkg::ADDR_W-1:0] addr, input logic [3:0] id,
			input logic [3:0] len, input logic [2:0] size, input logic [1:0] burst,
			input logic [axi_wr_pkg::DATA_W-1:0] base, input logic [3:0] strb,
			input logic [1:0] resp);
		tbl_name[i] = name;
		tbl_cmd[i] = '{addr: addr, id: id, len: len, size: size, burst: burst};
		tbl_base[i] = base;
		tbl_strb[i] = strb;
		tbl_resp[i] = resp;
	endtask

	task automatic push_row(input int row);
		for (int k = 0; k <= int'(tbl_cmd[row].len); k++) begin
			beat_in <= '{data: tbl_base[row] + axi_wr_pkg::DATA_W'(k), strb: tbl_strb[row]};
			beat_valid <= 1'b1;
			@(posedge AClk);
			while (!beat_ready) begin
				@(posedge AClk);
			end
		end
		beat_valid <= 1'b0;
	endtask

	task automatic send_cmd(input int row);
		cmd <= tbl_cmd[row];
		cmd_valid <= 1'b1;
		@(posedge AClk);
		while (!cmd_ready) begin
			@(posedge AClk);
		end
		cmd_valid <= 1'b0;
	endtask

	//////////////////////////////
	// AXI slave model
	//////////////////////////////
	always @(posedge AClk) begin
		if (!ARst) begin
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			// ready about three cycles in four
			aw_ready <= (($random(seed) & 3) != 0);
			w_ready <= (($random(seed) & 3) != 0);
			if (aw_valid && aw_ready) begin
				rsp_word.resp = (aw_seen < N_ROWS) ? tbl_resp[aw_seen] : axi_wr_pkg::RESP_OKAY;
				rsp_word.id = aw.id;
				open_q.push_back(rsp_word);
				aw_seen++;
			end
			if (w_valid && w_ready && w_last && open_q.size() > 0) begin
				b_q.push_back(open_q.pop_front());
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
			end else if (!b_valid && b_q.size() > 0) begin
				b <= b_q.pop_front();
				b_valid <= 1'b1;
			end
		end
	end

	initial begin : main_seq
		int total;
		ARst = 1'b0;
		cmd = '0;
		cmd_valid = 1'b0;
		beat_in = '0;
		beat_valid = 1'b0;
		add_row(0, "single", 32'h0000_1000, 4'h1, 4'd0, 3'd2, axi_wr_pkg::BURST_INCR,
			32'h1000_0000, 4'hf, axi_wr_pkg::RESP_OKAY);
		add_row(1, "incr4", 32'h0000_2040, 4'h2, 4'd3, 3'd2, axi_wr_pkg::BURST_INCR,
			32'h2000_0000, 4'hf, axi_wr_pkg::RESP_OKAY);
		add_row(2, "full16", 32'h0001_0000, 4'h3, 4'd15, 3'd2, axi_wr_pkg::BURST_INCR,
			32'h3000_0100, 4'hf, axi_wr_pkg::RESP_EXOKAY);
		add_row(3, "wrap8_strb", 32'h0000_3010, 4'h4, 4'd7, 3'd2, axi_wr_pkg::BURST_WRAP,
			32'h4000_0000, 4'b0110, axi_wr_pkg::RESP_SLVERR);
		add_row(4, "fixed2", 32'h0000_4000, 4'h9, 4'd1, 3'd1, axi_wr_pkg::BURST_FIXED,
			32'h5000_ffff, 4'hf, axi_wr_pkg::RESP_DECERR);
		add_row(5, "incr16_last", 32'h0000_5000, 4'hf, 4'd15, 3'd2, axi_wr_pkg::BURST_INCR,
			32'hffff_fff8, 4'hf, axi_wr_pkg::RESP_OKAY);
		repeat (2) @(posedge AClk);
		ARst <= 1'b1;
		for (int i = 0; i < N_ROWS; i++) begin
			// next row's beats go in while this burst still drains
			push_row(i);
			send_cmd(i);
		end
		while (rsp_count < N_ROWS) begin
			@(posedge AClk);
		end
		// quiet tail to catch stray pulses
		repeat (10) @(posedge AClk);
		total = err_count + u_dut.u_checker.fail_count;
		$display("done: %0d of %0d responses, %0d monitor errors, %0d assertion failures",
			rsp_count, N_ROWS, err_count, u_dut.u_checker.fail_count);
		if (total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin : watchdog
		int beats;
		int limit;
		beats = 0;
		@(posedge AClk);
		for (int i = 0; i < N_ROWS; i++) begin
			beats += int'(tbl_cmd[i].len) + 1;
		end
		limit = beats * BEAT_ALLOW + MARGIN;
		repeat (limit) @(posedge AClk);
		$display("ERROR: watchdog expired after %0d cycles, the run did not finish", limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
